// ==== source/yuv420_pkg.sv ====
package yuv420_pkg;

   // item codes carried on the dtype bus
   typedef enum logic [3:0] {
      dt_idle         = 4'd0,
      dt_frame_start  = 4'd1,
      dt_frame_end    = 4'd2,
      dt_header_start = 4'd3,
      dt_header       = 4'd4,
      dt_header_end   = 4'd5,
      dt_row_start    = 4'd6,
      dt_row_end      = 4'd7,
      dt_pixel        = 4'd8
   } dtype_e;

   // how pixel bytes are packed into the output words
   typedef enum logic [1:0] {
      mode_raw    = 2'd0,
      mode_yuv444 = 2'd1,
      mode_yuv420 = 2'd2
   } out_mode_e;

   // widest row the chroma line buffer can hold
   localparam int max_cols = 1288;

   // row and column counter width
   localparam int dim_width = 11;

   // low bits of meta data dropped to form the raw byte
   localparam int raw_pixel_shift = 0;

   // header word that carries image_type instead of meta data
   localparam int image_type_index = 0;

   // one full word plus the largest append of three bytes
   localparam int obuf_width = 56;

   // bit count of the packing buffer fill
   localparam int fill_width = $clog2(obuf_width);

endpackage

// ==== source/stream_decode.sv ====
module stream_decode (
   input  logic                               clk,
   input  logic                               resetb,
   input  logic                               dv,
   input  yuv420_pkg::dtype_e                 dtype,
   input  logic [15:0]                        meta_data,
   input  logic [7:0]                         y,
   input  logic [7:0]                         u,
   input  logic [7:0]                         v,
   input  logic [15:0]                        image_type,
   input  logic                               enable_420,
   output logic                               dv_d,
   output yuv420_pkg::dtype_e                 dtype_d,
   output logic                               pixel_valid,
   output logic                               frame_start,
   output logic                               frame_end,
   output logic                               header_start,
   output logic                               header_valid,
   output logic [7:0]                         y_d,
   output logic [7:0]                         u_d,
   output logic [7:0]                         v_d,
   output logic [15:0]                        meta_d,
   output logic [15:0]                        image_type_d,
   output yuv420_pkg::out_mode_e              mode,
   output logic [yuv420_pkg::dim_width-1:0]   col_pos,
   output logic                               row_odd,
   output logic                               col_odd
);
   import yuv420_pkg::*;

   logic                 enable_420_d;
   logic                 row_start;
   logic                 row_end;
   logic [dim_width-1:0] col_cnt;
   logic [dim_width-1:0] row_cnt;

   always_ff @(posedge clk or negedge resetb) begin
      if (!resetb) begin
         dv_d    <= 1'b0;
         dtype_d <= dt_idle;
      end else begin
         dv_d    <= dv;
         dtype_d <= dtype;
      end
   end

   // data follows the strobe, no reset needed on the payload
   always_ff @(posedge clk) begin
      y_d          <= y;
      u_d          <= u;
      v_d          <= v;
      meta_d       <= meta_data;
      image_type_d <= image_type;
      enable_420_d <= enable_420;
   end

   assign pixel_valid  = dv_d && (dtype_d == dt_pixel);
   assign frame_start  = dv_d && (dtype_d == dt_frame_start);
   assign frame_end    = dv_d && (dtype_d == dt_frame_end);
   assign header_start = dv_d && (dtype_d == dt_header_start);
   assign header_valid = dv_d && (dtype_d == dt_header);
   assign row_start    = dv_d && (dtype_d == dt_row_start);
   assign row_end      = dv_d && (dtype_d == dt_row_end);

   // image_type of zero selects raw bytes regardless of enable_420
   assign mode = (image_type_d == 16'd0) ? mode_raw :
                 enable_420_d            ? mode_yuv420 : mode_yuv444;

   // position of the pixel now in the registered stage
   always_ff @(posedge clk or negedge resetb) begin
      if (!resetb) begin
         col_cnt <= '0;
         row_cnt <= '0;
      end else begin
         if (row_start) begin
            col_cnt <= '0;
         end else if (pixel_valid) begin
            col_cnt <= col_cnt + 1'b1;
         end
         if (frame_start) begin
            row_cnt <= '0;
         end else if (row_end) begin
            row_cnt <= row_cnt + 1'b1;
         end
      end
   end

   assign col_pos = col_cnt;
   assign col_odd = col_cnt[0];
   assign row_odd = row_cnt[0];

   // the line buffer in the kernel is only max_cols deep
   a_col_in_range : assert property (@(posedge clk) disable iff (!resetb)
      pixel_valid |-> (col_cnt < max_cols));

endmodule

// ==== source/chroma_kernel.sv ====
module chroma_kernel (
   input  logic                               clk,
   input  logic                               resetb,
   input  logic                               pixel_valid,
   input  logic [7:0]                         u_d,
   input  logic [7:0]                         v_d,
   input  logic [yuv420_pkg::dim_width-1:0]   col_pos,
   output logic [7:0]                         u_ave,
   output logic [7:0]                         v_ave
);
   import yuv420_pkg::*;

   // previous row of chroma, u in the high byte
   logic [15:0] line_buf [0:max_cols-1];

   logic [15:0] above;
   logic [15:0] above_left;
   logic [15:0] left;

   function automatic logic [7:0] avg4(input logic [7:0] a, input logic [7:0] b,
                                       input logic [7:0] c, input logic [7:0] d);
      logic [9:0] sum;
      sum = 10'(a) + 10'(b) + 10'(c) + 10'(d);
      return sum[9:2];
   endfunction

   // the entry at col_pos still holds the row above until this pixel is written
   assign above = line_buf[col_pos];

   always_ff @(posedge clk) begin
      if (pixel_valid) begin
         line_buf[col_pos] <= {u_d, v_d};
      end
   end

   // above_left is the row-above value read one pixel earlier,
   // so it stands for the line buffer at col_pos-1
   always_ff @(posedge clk or negedge resetb) begin
      if (!resetb) begin
         above_left <= '0;
         left       <= '0;
      end else if (pixel_valid) begin
         above_left <= above;
         left       <= {u_d, v_d};
      end
   end

   assign u_ave = avg4(above_left[15:8], above[15:8], left[15:8], u_d);
   assign v_ave = avg4(above_left[7:0], above[7:0], left[7:0], v_d);

endmodule

// ==== source/word_packer.sv ====
module word_packer (
   input  logic                    clk,
   input  logic                    resetb,
   input  logic                    pixel_valid,
   input  logic                    frame_start,
   input  logic                    frame_end,
   input  logic                    header_start,
   input  logic                    header_valid,
   input  logic                    dv_d,
   input  yuv420_pkg::dtype_e      dtype_d,
   input  logic [7:0]              y_d,
   input  logic [7:0]              u_d,
   input  logic [7:0]              v_d,
   input  logic [15:0]             meta_d,
   input  logic [15:0]             image_type_d,
   input  yuv420_pkg::out_mode_e   mode,
   input  logic                    row_odd,
   input  logic                    col_odd,
   input  logic [7:0]              u_ave,
   input  logic [7:0]              v_ave,
   output logic                    dvo,
   output yuv420_pkg::dtype_e      dtypeo,
   output logic [31:0]             datao
);
   import yuv420_pkg::*;

   logic [obuf_width-1:0] obuf;
   logic [obuf_width-1:0] next_obuf;
   logic [fill_width-1:0] fill;
   logic [fill_width-1:0] next_fill;
   logic [fill_width-1:0] out_shift;
   logic [obuf_width-1:0] shifted;
   logic [31:0]           word;
   logic [7:0]            raw_byte;
   logic [15:0]           hdr_word;
   logic [7:0]            hdr_cnt;
   logic                  flush_req;
   logic                  flushed;

   assign raw_byte  = 8'(meta_d >> raw_pixel_shift);
   assign flush_req = frame_end && (fill != '0);
   assign hdr_word  = (hdr_cnt == image_type_index) ? image_type_d : meta_d;

   // append this pixel's bytes, newest at the bottom
   always_comb begin
      next_obuf = obuf;
      next_fill = fill;
      if (flush_req) begin
         // move leftover bytes to the top of a word, zeros below
         next_obuf = obuf << (6'd32 - fill);
         next_fill = 6'd32;
      end else begin
         case (mode)
            mode_raw: begin
               next_obuf = {obuf[obuf_width-9:0], raw_byte};
               next_fill = fill + 6'd8;
            end
            mode_yuv444: begin
               next_obuf = {obuf[obuf_width-25:0], y_d, u_d, v_d};
               next_fill = fill + 6'd24;
            end
            default: begin
               if (row_odd && col_odd) begin
                  next_obuf = {obuf[obuf_width-25:0], y_d, u_ave, v_ave};
                  next_fill = fill + 6'd24;
               end else begin
                  next_obuf = {obuf[obuf_width-9:0], y_d};
                  next_fill = fill + 6'd8;
               end
            end
         endcase
      end
   end

   // oldest four bytes, then byte swapped so the first lands in [7:0]
   assign out_shift = next_fill - 6'd32;
   assign shifted   = next_obuf >> out_shift;
   assign word      = {shifted[7:0], shifted[15:8], shifted[23:16], shifted[31:24]};

   always_ff @(posedge clk) begin
      if (pixel_valid || flush_req) begin
         obuf <= next_obuf;
      end
   end

   always_ff @(posedge clk or negedge resetb) begin
      if (!resetb) begin
         dvo     <= 1'b0;
         dtypeo  <= dt_idle;
         datao   <= '0;
         fill    <= '0;
         hdr_cnt <= '0;
         flushed <= 1'b0;
      end else begin
         flushed <= flush_req;
         if (pixel_valid || flush_req) begin
            dtypeo <= flush_req ? dt_pixel : dtype_d;
            if (next_fill >= 6'd32) begin
               dvo   <= 1'b1;
               datao <= word;
               fill  <= out_shift;
            end else begin
               dvo   <= 1'b0;
               datao <= '0;
               fill  <= next_fill;
            end
         end else if (flushed) begin
            // trailing frame_end after the padded word
            dvo    <= 1'b1;
            dtypeo <= dt_frame_end;
            datao  <= '0;
         end else if (frame_start || header_start) begin
            dvo     <= 1'b1;
            dtypeo  <= dtype_d;
            datao   <= '0;
            hdr_cnt <= '0;
            if (frame_start) begin
               fill <= '0;
            end
         end else if (header_valid) begin
            dtypeo  <= dtype_d;
            hdr_cnt <= hdr_cnt + 1'b1;
            if (hdr_cnt[0]) begin
               datao[31:16] <= hdr_word;
               dvo          <= 1'b1;
            end else begin
               datao[15:0] <= hdr_word;
               dvo         <= 1'b0;
            end
         end else begin
            dvo    <= dv_d;
            dtypeo <= dtype_d;
            datao  <= '0;
         end
      end
   end

   a_fill_bound : assert property (@(posedge clk) disable iff (!resetb)
      fill < obuf_width);

endmodule

// ==== source/yuv420_formatter.sv ====
module yuv420_formatter (
   input  logic                 clk,
   input  logic                 resetb,
   input  logic                 dv,
   input  yuv420_pkg::dtype_e   dtype,
   input  logic [15:0]          meta_data,
   input  logic [7:0]           y,
   input  logic [7:0]           u,
   input  logic [7:0]           v,
   input  logic [15:0]          image_type,
   input  logic                 enable_420,
   output logic                 dvo,
   output yuv420_pkg::dtype_e   dtypeo,
   output logic [31:0]          datao
);
   import yuv420_pkg::*;

   logic                 dv_d;
   dtype_e               dtype_d;
   logic                 pixel_valid;
   logic                 frame_start;
   logic                 frame_end;
   logic                 header_start;
   logic                 header_valid;
   logic [7:0]           y_d;
   logic [7:0]           u_d;
   logic [7:0]           v_d;
   logic [15:0]          meta_d;
   logic [15:0]          image_type_d;
   out_mode_e            mode;
   logic [dim_width-1:0] col_pos;
   logic                 row_odd;
   logic                 col_odd;
   logic [7:0]           u_ave;
   logic [7:0]           v_ave;

   stream_decode decode0 (
      .clk(clk), .resetb(resetb), .dv(dv), .dtype(dtype), .meta_data(meta_data),
      .y(y), .u(u), .v(v), .image_type(image_type), .enable_420(enable_420),
      .dv_d(dv_d), .dtype_d(dtype_d), .pixel_valid(pixel_valid),
      .frame_start(frame_start), .frame_end(frame_end), .header_start(header_start),
      .header_valid(header_valid), .y_d(y_d), .u_d(u_d), .v_d(v_d), .meta_d(meta_d),
      .image_type_d(image_type_d), .mode(mode), .col_pos(col_pos),
      .row_odd(row_odd), .col_odd(col_odd)
   );

   chroma_kernel kernel0 (
      .clk(clk), .resetb(resetb), .pixel_valid(pixel_valid), .u_d(u_d), .v_d(v_d),
      .col_pos(col_pos), .u_ave(u_ave), .v_ave(v_ave)
   );

   word_packer packer0 (
      .clk(clk), .resetb(resetb), .pixel_valid(pixel_valid), .frame_start(frame_start),
      .frame_end(frame_end), .header_start(header_start), .header_valid(header_valid),
      .dv_d(dv_d), .dtype_d(dtype_d), .y_d(y_d), .u_d(u_d), .v_d(v_d), .meta_d(meta_d),
      .image_type_d(image_type_d), .mode(mode), .row_odd(row_odd), .col_odd(col_odd),
      .u_ave(u_ave), .v_ave(v_ave), .dvo(dvo), .dtypeo(dtypeo), .datao(datao)
   );

endmodule

// ==== verification/tb_yuv420_formatter.sv ====
module tb_yuv420_formatter;
   import yuv420_pkg::*;

   logic        clk;
   logic        resetb;
   logic        dv;
   dtype_e      dtype;
   logic [15:0] meta_data;
   logic [7:0]  y;
   logic [7:0]  u;
   logic [7:0]  v;
   logic [15:0] image_type;
   logic        enable_420;
   logic        dvo;
   dtype_e      dtypeo;
   logic [31:0] datao;

   integer      seed;
   logic        quiet_window;
   // expected output words in order, head copied out for the assertions
   dtype_e      exp_type[$];
   logic [31:0] exp_data[$];
   logic [7:0]  exp_bytes[$];
   logic        head_valid;
   dtype_e      head_type;
   logic [31:0] head_data;
   // chroma of the current frame, used for the 2x2 averages
   logic [7:0]  ref_u [0:3][0:5];
   logic [7:0]  ref_v [0:3][0:5];

   yuv420_formatter dut0 (
      .clk(clk), .resetb(resetb), .dv(dv), .dtype(dtype), .meta_data(meta_data),
      .y(y), .u(u), .v(v), .image_type(image_type), .enable_420(enable_420),
      .dvo(dvo), .dtypeo(dtypeo), .datao(datao)
   );

   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   task automatic abort_run(input string why);
      $display("*** FAILED ***");
      $fatal(1, "%s", why);
   endtask

   // retire the head each time the DUT presents a word
   always @(posedge clk) begin
      if (dvo && exp_data.size() != 0) begin
         void'(exp_type.pop_front());
         void'(exp_data.pop_front());
      end
      if (exp_data.size() != 0) begin
         head_valid <= 1'b1;
         head_type  <= exp_type[0];
         head_data  <= exp_data[0];
      end else begin
         head_valid <= 1'b0;
      end
   end

   a_reset_quiet : assert property (@(posedge clk)
      quiet_window |-> (!dvo && dtypeo == dt_idle && datao == 32'h0))
      else begin
         $display("MISMATCH dvo/dtypeo/datao expected 0/%h/00000000 actual %h/%h/%h",
                  dt_idle, $sampled(dvo), $sampled(dtypeo), $sampled(datao));
         abort_run("outputs not idle around reset");
      end

   a_no_extra : assert property (@(posedge clk) disable iff (!resetb)
      dvo |-> head_valid)
      else begin
         $display("an output word with dtypeo %h came when no word was expected",
                  $sampled(dtypeo));
         abort_run("unexpected output word");
      end

   a_dtypeo : assert property (@(posedge clk) disable iff (!resetb)
      (dvo && head_valid) |-> (dtypeo == head_type))
      else begin
         $display("MISMATCH dtypeo expected %h actual %h",
                  $sampled(head_type), $sampled(dtypeo));
         abort_run("dtypeo check");
      end

   a_datao : assert property (@(posedge clk) disable iff (!resetb)
      (dvo && head_valid) |-> (datao == head_data))
      else begin
         $display("MISMATCH datao expected %h actual %h",
                  $sampled(head_data), $sampled(datao));
         abort_run("datao check");
      end

   task automatic put_item(input dtype_e t, input logic [15:0] meta,
                           input logic [7:0] py, input logic [7:0] pu, input logic [7:0] pv);
      @(posedge clk);
      #10;
      dv        = (t != dt_idle);
      dtype     = t;
      meta_data = meta;
      y         = py;
      u         = pu;
      v         = pv;
   endtask

   task automatic expect_word(input dtype_e t, input logic [31:0] d);
      exp_type.push_back(t);
      exp_data.push_back(d);
   endtask

   // first byte of the stream lands in datao[7:0]
   task automatic add_byte(input logic [7:0] b);
      exp_bytes.push_back(b);
      if (exp_bytes.size() == 4) begin
         expect_word(dt_pixel, {exp_bytes[3], exp_bytes[2], exp_bytes[1], exp_bytes[0]});
         exp_bytes.delete();
      end
   endtask

   task automatic wait_drained(input int limit);
      int cycles;
      cycles = 0;
      while (exp_data.size() != 0) begin
         if (cycles >= limit) begin
            $display("timeout, %0d expected output words never arrived", exp_data.size());
            abort_run("timeout waiting for dvo");
         end else begin
            @(posedge clk);
            cycles = cycles + 1;
         end
      end
   endtask

   task automatic run_frame(input int rows, input int cols, input logic [15:0] itype,
                            input logic en420);
      logic [31:0] rnd;
      logic [15:0] hdr [0:3];
      logic [15:0] meta;
      logic [7:0]  py;
      logic [7:0]  pu;
      logic [7:0]  pv;
      logic [9:0]  sum_u;
      logic [9:0]  sum_v;
      int          k;
      int          r;
      int          c;
      @(posedge clk);
      #10;
      image_type = itype;
      enable_420 = en420;
      put_item(dt_frame_start, 16'h0, 8'h0, 8'h0, 8'h0);
      expect_word(dt_frame_start, 32'h0);
      put_item(dt_header_start, 16'h0, 8'h0, 8'h0, 8'h0);
      expect_word(dt_header_start, 32'h0);
      // header word 0 is replaced by image_type
      for (k = 0; k < 4; k = k + 1) begin
         rnd = $random(seed);
         hdr[k] = rnd[15:0];
         put_item(dt_header, hdr[k], 8'h0, 8'h0, 8'h0);
         if (k == 1) expect_word(dt_header, {hdr[1], itype});
         if (k == 3) expect_word(dt_header, {hdr[3], hdr[2]});
      end
      put_item(dt_header_end, 16'h0, 8'h0, 8'h0, 8'h0);
      expect_word(dt_header_end, 32'h0);
      for (r = 0; r < rows; r = r + 1) begin
         put_item(dt_row_start, 16'h0, 8'h0, 8'h0, 8'h0);
         expect_word(dt_row_start, 32'h0);
         for (c = 0; c < cols; c = c + 1) begin
            rnd = $random(seed);
            py = rnd[7:0];
            pu = rnd[15:8];
            pv = rnd[23:16];
            rnd = $random(seed);
            meta = rnd[15:0];
            ref_u[r][c] = pu;
            ref_v[r][c] = pv;
            put_item(dt_pixel, meta, py, pu, pv);
            if (itype == 16'h0) begin
               add_byte(meta[7:0]);
            end else if (!en420) begin
               add_byte(py);
               add_byte(pu);
               add_byte(pv);
            end else begin
               add_byte(py);
               // odd row and odd column close a 2x2 block
               if ((r % 2 == 1) && (c % 2 == 1)) begin
                  sum_u = {2'b0, ref_u[r-1][c-1]} + {2'b0, ref_u[r-1][c]} +
                          {2'b0, ref_u[r][c-1]} + {2'b0, pu};
                  sum_v = {2'b0, ref_v[r-1][c-1]} + {2'b0, ref_v[r-1][c]} +
                          {2'b0, ref_v[r][c-1]} + {2'b0, pv};
                  add_byte(sum_u[9:2]);
                  add_byte(sum_v[9:2]);
               end
            end
         end
         put_item(dt_row_end, 16'h0, 8'h0, 8'h0, 8'h0);
         expect_word(dt_row_end, 32'h0);
      end
      put_item(dt_frame_end, 16'h0, 8'h0, 8'h0, 8'h0);
      // leftover bytes go out zero padded before the frame_end word
      while (exp_bytes.size() != 0) begin
         add_byte(8'h00);
      end
      expect_word(dt_frame_end, 32'h0);
      put_item(dt_idle, 16'h0, 8'h0, 8'h0, 8'h0);
      put_item(dt_idle, 16'h0, 8'h0, 8'h0, 8'h0);
      wait_drained(10);
   endtask

   initial begin
      seed         = 32'ha4180d92;
      resetb       = 1'b0;
      dv           = 1'b0;
      dtype        = dt_idle;
      meta_data    = 16'h0;
      y            = 8'h0;
      u            = 8'h0;
      v            = 8'h0;
      image_type   = 16'h0;
      enable_420   = 1'b0;
      quiet_window = 1'b0;
      @(posedge clk);
      #10;
      quiet_window = 1'b1;
      repeat (4) @(posedge clk);
      #10;
      resetb = 1'b1;
      repeat (3) @(posedge clk);
      #10;
      quiet_window = 1'b0;
      // 4:4:4, then 4:2:0, then raw bytes
      run_frame(4, 6, 16'h0005, 1'b0);
      run_frame(4, 6, 16'h0005, 1'b1);
      run_frame(4, 6, 16'h0000, 1'b0);
      // 27 and 5 bytes, both end on a partial word
      run_frame(3, 3, 16'h0002, 1'b0);
      run_frame(1, 5, 16'h0000, 1'b0);
      repeat (4) @(posedge clk);
      $display("*** PASSED ***");
      $finish;
   end

endmodule

// ==== all.f ====
source/yuv420_pkg.sv
source/stream_decode.sv
source/chroma_kernel.sv
source/word_packer.sv
source/yuv420_formatter.sv
verification/tb_yuv420_formatter.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       := tb_yuv420_formatter
FILELIST  := all.f
OBJ_DIR   := obj_dir
FLAGS     := --binary --timing --assert -Wno-fatal -j 0
LINT_FLAGS := --lint-only --timing -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
